// File: Makefile
VERILATOR ?= verilator
TOP       := operand_unit_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "Verification passed" $(LOG) || (echo "Simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
design/gpu_config_pkg.sv
design/gpu_regfile_pkg.sv
design/operand_ifs.sv
design/elastic_buffer.sv
design/gpr_bank.sv
design/operand_collector.sv
design/operand_unit.sv
dv/operand_unit_asserts.sv
dv/operand_unit_tb.sv

// File: design/elastic_buffer.sv
module elastic_buffer #(
    parameter int DATAW = 8,
    parameter int SIZE  = 1
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             valid_in,
    output logic             ready_in,
    input  logic [DATAW-1:0] data_in,
    output logic             valid_out,
    input  logic             ready_out,
    output logic [DATAW-1:0] data_out
);
    logic             out_valid;
    logic [DATAW-1:0] out_data;

    assign valid_out = out_valid;
    assign data_out  = out_data;

    if (SIZE == 1) begin : g_pipe
        // A new word may enter in the same cycle the held one leaves
        assign ready_in = !out_valid || ready_out;

        always_ff @(posedge clk) begin
            if (reset) begin
                out_valid <= 1'b0;
            end else if (ready_in) begin
                out_valid <= valid_in;
            end
        end

        always_ff @(posedge clk) begin
            if (ready_in) begin
                out_data <= data_in;
            end
        end
    end else begin : g_skid
        logic             skid_valid;
        logic [DATAW-1:0] skid_data;

        // Input side only sees whether the skid slot is taken
        assign ready_in = !skid_valid;

        always_ff @(posedge clk) begin
            if (reset) begin
                out_valid  <= 1'b0;
                skid_valid <= 1'b0;
            end else if (!out_valid || ready_out) begin
                out_valid  <= skid_valid || valid_in;
                skid_valid <= 1'b0;
            end else if (valid_in && !skid_valid) begin
                skid_valid <= 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (!out_valid || ready_out) begin
                out_data <= skid_valid ? skid_data : data_in;
            end else if (!skid_valid) begin
                skid_data <= data_in;
            end
        end
    end

endmodule

// File: design/gpr_bank.sv
module gpr_bank #(
    parameter int THREAD_CNT = gpu_config_pkg::NUM_LANES
) (
    input  logic                                              clk,
    input  logic [THREAD_CNT-1:0]                             write,
    input  logic [gpu_regfile_pkg::RA_BITS-1:0]               waddr,
    input  logic [THREAD_CNT-1:0][gpu_config_pkg::XLEN-1:0]   wdata,
    input  logic [gpu_regfile_pkg::RA_BITS-1:0]               raddr,
    output logic [THREAD_CNT-1:0][gpu_config_pkg::XLEN-1:0]   rdata
);
    import gpu_config_pkg::*;
    import gpu_regfile_pkg::*;

    // One independent bank per lane so a masked write touches only its lanes
    for (genvar j = 0; j < THREAD_CNT; j++) begin : g_lane
        logic [XLEN-1:0] mem [NUM_ROWS];

        always_ff @(posedge clk) begin
            if (write[j]) begin
                mem[waddr] <= wdata[j];
            end
        end

        // All lanes read the same row, the address is already registered upstream
        assign rdata[j] = mem[raddr];
    end

endmodule

// File: design/gpu_config_pkg.sv
package gpu_config_pkg;

    // Operand width in bits
    localparam int XLEN = 32;

    // Thread lanes per warp
    localparam int NUM_LANES = 4;

    // Architectural registers per warp
    localparam int NUM_REGS = 32;
    localparam int NR_BITS  = $clog2(NUM_REGS);

    // Warp slots that share one operand stage
    localparam int NUM_WARP_SLOTS = 4;
    localparam int WIS_BITS       = $clog2(NUM_WARP_SLOTS);

    // Instruction tag, only carried along for tracking
    localparam int UUID_BITS = 8;

    // Opcode is opaque to this stage and passes straight through
    localparam int OP_BITS = 8;

endpackage

// File: design/gpu_regfile_pkg.sv
package gpu_regfile_pkg;

    import gpu_config_pkg::*;

    // One bank row per register and warp slot
    localparam int RA_BITS  = NR_BITS + WIS_BITS;
    localparam int NUM_ROWS = NUM_REGS * NUM_WARP_SLOTS;

    // Collector FSM encoding, fetch states follow source order
    localparam int STATE_BITS = 2;
    localparam logic [STATE_BITS-1:0] ST_IDLE   = 2'd0;
    localparam logic [STATE_BITS-1:0] ST_FETCH1 = 2'd1;
    localparam logic [STATE_BITS-1:0] ST_FETCH2 = 2'd2;
    localparam logic [STATE_BITS-1:0] ST_FETCH3 = 2'd3;

    function automatic logic [RA_BITS-1:0] reg_addr(
        input logic [NR_BITS-1:0]  rid,
        input logic [WIS_BITS-1:0] wis
    );
        return {rid, wis};
    endfunction

endpackage

// File: design/operand_collector.sv
module operand_collector #(
    parameter int THREAD_CNT   = gpu_config_pkg::NUM_LANES,
    parameter int CACHE_ENABLE = 1
) (
    input  logic       clk,
    input  logic       reset,
    issue_if.slave     issue,
    writeback_if.slave wb,
    operands_if.master opd
);
    import gpu_config_pkg::*;
    import gpu_regfile_pkg::*;

    localparam int META_W = UUID_BITS + WIS_BITS + THREAD_CNT + XLEN + NR_BITS + OP_BITS;
    localparam int VEC_W  = THREAD_CNT * XLEN;
    localparam int OUT_W  = META_W + 3 * VEC_W;

    logic [STATE_BITS-1:0] state, state_n;
    logic                  data_ready, data_ready_n;
    logic [NR_BITS-1:0]    rd_rid, rd_rid_n;
    logic [WIS_BITS-1:0]   rd_wis, rd_wis_n;
    logic [NR_BITS-1:0]    rs2_q, rs2_q_n;
    logic [NR_BITS-1:0]    rs3_q, rs3_q_n;
    logic                  rs2_need, rs2_need_n;
    logic                  rs3_need, rs3_need_n;

    // Operand registers, index 0 holds rs1
    logic [2:0][THREAD_CNT-1:0][XLEN-1:0] opnd, opnd_n;
    logic [THREAD_CNT-1:0][XLEN-1:0]      gpr_rdata;

    // One cached register per warp slot, the last one written
    logic [NUM_WARP_SLOTS-1:0][THREAD_CNT-1:0][XLEN-1:0] cache_data, cache_data_n;
    logic [NUM_WARP_SLOTS-1:0][NR_BITS-1:0]              cache_reg, cache_reg_n;
    logic [NUM_WARP_SLOTS-1:0][THREAD_CNT-1:0]           cache_tmask, cache_tmask_n;
    logic [NUM_WARP_SLOTS-1:0]                           cache_eop, cache_eop_n;

    logic [2:0][NR_BITS-1:0] issue_src;
    logic [2:0]              src_hit;
    logic                    issue_fire;
    logic [META_W-1:0]       stg_meta;
    logic                    stg_valid, stg_ready;
    logic                    out_valid_in, out_ready_in;
    logic [OUT_W-1:0]        out_data;

    assign issue_src  = {issue.rs3, issue.rs2, issue.rs1};
    assign issue_fire = issue.valid && issue.ready;

    // A source needs no fetch when it is r0 or the cache covers every active lane
    always_comb begin
        for (int k = 0; k < 3; k++) begin
            src_hit[k] = (issue_src[k] == '0)
                      || (CACHE_ENABLE != 0 && issue_src[k] == cache_reg[issue.wis]
                          && (issue.tmask & ~cache_tmask[issue.wis]) == '0);
        end
    end

    always_comb begin
        state_n       = state;
        data_ready_n  = data_ready;
        rd_rid_n      = rd_rid;
        rd_wis_n      = rd_wis;
        rs2_q_n       = rs2_q;
        rs3_q_n       = rs3_q;
        rs2_need_n    = rs2_need;
        rs3_need_n    = rs3_need;
        opnd_n        = opnd;
        cache_data_n  = cache_data;
        cache_reg_n   = cache_reg;
        cache_tmask_n = cache_tmask;
        cache_eop_n   = cache_eop;

        case (state)
            ST_IDLE: begin
                if (stg_valid && stg_ready) begin
                    data_ready_n = 1'b0;
                end
                if (issue_fire) begin
                    for (int k = 0; k < 3; k++) begin
                        if (src_hit[k]) begin
                            opnd_n[k] = (issue_src[k] == '0) ? '0 : cache_data[issue.wis];
                        end
                    end
                    rs2_q_n    = issue.rs2;
                    rs3_q_n    = issue.rs3;
                    rs2_need_n = !src_hit[1];
                    rs3_need_n = !src_hit[2];
                    rd_wis_n   = issue.wis;
                    if (!src_hit[0]) begin
                        rd_rid_n = issue.rs1;
                        state_n  = ST_FETCH1;
                    end else if (!src_hit[1]) begin
                        rd_rid_n = issue.rs2;
                        state_n  = ST_FETCH2;
                    end else if (!src_hit[2]) begin
                        rd_rid_n = issue.rs3;
                        state_n  = ST_FETCH3;
                    end else begin
                        data_ready_n = 1'b1;
                    end
                end
            end
            ST_FETCH1: begin
                opnd_n[0] = gpr_rdata;
                if (rs2_need) begin
                    rd_rid_n = rs2_q;
                    state_n  = ST_FETCH2;
                end else if (rs3_need) begin
                    rd_rid_n = rs3_q;
                    state_n  = ST_FETCH3;
                end else begin
                    data_ready_n = 1'b1;
                    state_n      = ST_IDLE;
                end
            end
            ST_FETCH2: begin
                opnd_n[1] = gpr_rdata;
                if (rs3_need) begin
                    rd_rid_n = rs3_q;
                    state_n  = ST_FETCH3;
                end else begin
                    data_ready_n = 1'b1;
                    state_n      = ST_IDLE;
                end
            end
            default: begin
                opnd_n[2]    = gpr_rdata;
                data_ready_n = 1'b1;
                state_n      = ST_IDLE;
            end
        endcase

        // Refill on the first part of a new packet, merge later parts of the same one
        if (CACHE_ENABLE != 0 && wb.valid) begin
            if (cache_reg[wb.wis] == wb.rd || (cache_eop[wb.wis] && wb.sop)) begin
                for (int j = 0; j < THREAD_CNT; j++) begin
                    if (wb.tmask[j]) begin
                        cache_data_n[wb.wis][j] = wb.data[j];
                    end
                end
                cache_reg_n[wb.wis] = wb.rd;
                cache_eop_n[wb.wis] = wb.eop;
                if (wb.sop) begin
                    cache_tmask_n[wb.wis] = wb.tmask;
                end else begin
                    cache_tmask_n[wb.wis] = cache_tmask[wb.wis] | wb.tmask;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= ST_IDLE;
            data_ready  <= 1'b0;
            rd_rid      <= '0;
            rd_wis      <= '0;
            rs2_need    <= 1'b0;
            rs3_need    <= 1'b0;
            cache_reg   <= '0;
            cache_tmask <= '0;
            cache_eop   <= '1;
        end else begin
            state       <= state_n;
            data_ready  <= data_ready_n;
            rd_rid      <= rd_rid_n;
            rd_wis      <= rd_wis_n;
            rs2_need    <= rs2_need_n;
            rs3_need    <= rs3_need_n;
            cache_reg   <= cache_reg_n;
            cache_tmask <= cache_tmask_n;
            cache_eop   <= cache_eop_n;
        end
    end

    always_ff @(posedge clk) begin
        rs2_q      <= rs2_q_n;
        rs3_q      <= rs3_q_n;
        opnd       <= opnd_n;
        cache_data <= cache_data_n;
    end

    gpr_bank #(
        .THREAD_CNT (THREAD_CNT)
    ) i_gpr_bank (
        .clk   (clk),
        .write (wb.tmask & {THREAD_CNT{wb.valid}}),
        .waddr (reg_addr(wb.rd, wb.wis)),
        .wdata (wb.data),
        .raddr (reg_addr(rd_rid, rd_wis)),
        .rdata (gpr_rdata)
    );

    elastic_buffer #(
        .DATAW (META_W),
        .SIZE  (1)
    ) stg_buf (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (issue.valid),
        .ready_in  (issue.ready),
        .data_in   ({issue.uuid, issue.wis, issue.tmask, issue.pc, issue.rd, issue.op}),
        .valid_out (stg_valid),
        .ready_out (stg_ready),
        .data_out  (stg_meta)
    );

    // Staging only moves on once all three operand registers are filled
    assign out_valid_in = stg_valid && data_ready;
    assign stg_ready    = out_ready_in && data_ready;

    elastic_buffer #(
        .DATAW (OUT_W),
        .SIZE  (2)
    ) out_buf (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (out_valid_in),
        .ready_in  (out_ready_in),
        .data_in   ({stg_meta, opnd[0], opnd[1], opnd[2]}),
        .valid_out (opd.valid),
        .ready_out (opd.ready),
        .data_out  (out_data)
    );

    assign {opd.uuid, opd.wis, opd.tmask, opd.pc, opd.rd, opd.op,
            opd.rs1_data, opd.rs2_data, opd.rs3_data} = out_data;

endmodule

// File: design/operand_ifs.sv
interface issue_if #(
    parameter int THREAD_CNT = gpu_config_pkg::NUM_LANES
);
    import gpu_config_pkg::*;

    logic                  valid;
    logic                  ready;
    logic [UUID_BITS-1:0]  uuid;
    logic [WIS_BITS-1:0]   wis;
    logic [THREAD_CNT-1:0] tmask;
    logic [XLEN-1:0]       pc;
    logic [NR_BITS-1:0]    rd;
    logic [OP_BITS-1:0]    op;
    logic [NR_BITS-1:0]    rs1;
    logic [NR_BITS-1:0]    rs2;
    logic [NR_BITS-1:0]    rs3;

    modport master (output valid, uuid, wis, tmask, pc, rd, op, rs1, rs2, rs3, input ready);
    modport slave  (input valid, uuid, wis, tmask, pc, rd, op, rs1, rs2, rs3, output ready);
endinterface

// Write-back has no back-pressure, every valid cycle is a write
interface writeback_if #(
    parameter int THREAD_CNT = gpu_config_pkg::NUM_LANES
);
    import gpu_config_pkg::*;

    logic                             valid;
    logic [WIS_BITS-1:0]              wis;
    logic [NR_BITS-1:0]               rd;
    logic [THREAD_CNT-1:0]            tmask;
    logic [THREAD_CNT-1:0][XLEN-1:0]  data;
    logic                             sop;
    logic                             eop;

    modport master (output valid, wis, rd, tmask, data, sop, eop);
    modport slave  (input valid, wis, rd, tmask, data, sop, eop);
endinterface

interface operands_if #(
    parameter int THREAD_CNT = gpu_config_pkg::NUM_LANES
);
    import gpu_config_pkg::*;

    logic                             valid;
    logic                             ready;
    logic [UUID_BITS-1:0]             uuid;
    logic [WIS_BITS-1:0]              wis;
    logic [THREAD_CNT-1:0]            tmask;
    logic [XLEN-1:0]                  pc;
    logic [NR_BITS-1:0]               rd;
    logic [OP_BITS-1:0]               op;
    logic [THREAD_CNT-1:0][XLEN-1:0]  rs1_data;
    logic [THREAD_CNT-1:0][XLEN-1:0]  rs2_data;
    logic [THREAD_CNT-1:0][XLEN-1:0]  rs3_data;

    modport master (output valid, uuid, wis, tmask, pc, rd, op, rs1_data, rs2_data, rs3_data,
                    input ready);
    modport slave  (input valid, uuid, wis, tmask, pc, rd, op, rs1_data, rs2_data, rs3_data,
                    output ready);
endinterface

// File: design/operand_unit.sv
module operand_unit #(
    parameter int THREAD_CNT   = gpu_config_pkg::NUM_LANES,
    parameter int CACHE_ENABLE = 1
) (
    input  logic                                             clk,
    input  logic                                             reset,
    input  logic                                             issue_valid,
    output logic                                             issue_ready,
    input  logic [gpu_config_pkg::UUID_BITS-1:0]             issue_uuid,
    input  logic [gpu_config_pkg::WIS_BITS-1:0]              issue_wis,
    input  logic [THREAD_CNT-1:0]                            issue_tmask,
    input  logic [gpu_config_pkg::XLEN-1:0]                  issue_pc,
    input  logic [gpu_config_pkg::NR_BITS-1:0]               issue_rd,
    input  logic [gpu_config_pkg::OP_BITS-1:0]               issue_op,
    input  logic [gpu_config_pkg::NR_BITS-1:0]               issue_rs1,
    input  logic [gpu_config_pkg::NR_BITS-1:0]               issue_rs2,
    input  logic [gpu_config_pkg::NR_BITS-1:0]               issue_rs3,
    input  logic                                             wb_valid,
    input  logic [gpu_config_pkg::WIS_BITS-1:0]              wb_wis,
    input  logic [gpu_config_pkg::NR_BITS-1:0]               wb_rd,
    input  logic [THREAD_CNT-1:0]                            wb_tmask,
    input  logic [THREAD_CNT-1:0][gpu_config_pkg::XLEN-1:0]  wb_data,
    input  logic                                             wb_sop,
    input  logic                                             wb_eop,
    output logic                                             opd_valid,
    input  logic                                             opd_ready,
    output logic [gpu_config_pkg::UUID_BITS-1:0]             opd_uuid,
    output logic [gpu_config_pkg::WIS_BITS-1:0]              opd_wis,
    output logic [THREAD_CNT-1:0]                            opd_tmask,
    output logic [gpu_config_pkg::XLEN-1:0]                  opd_pc,
    output logic [gpu_config_pkg::NR_BITS-1:0]               opd_rd,
    output logic [gpu_config_pkg::OP_BITS-1:0]               opd_op,
    output logic [THREAD_CNT-1:0][gpu_config_pkg::XLEN-1:0]  opd_rs1_data,
    output logic [THREAD_CNT-1:0][gpu_config_pkg::XLEN-1:0]  opd_rs2_data,
    output logic [THREAD_CNT-1:0][gpu_config_pkg::XLEN-1:0]  opd_rs3_data
);
    issue_if     #(.THREAD_CNT (THREAD_CNT)) issue ();
    writeback_if #(.THREAD_CNT (THREAD_CNT)) wb ();
    operands_if  #(.THREAD_CNT (THREAD_CNT)) opd ();

    assign {issue.valid, issue.uuid, issue.wis, issue.tmask, issue.pc, issue.rd, issue.op}
        = {issue_valid, issue_uuid, issue_wis, issue_tmask, issue_pc, issue_rd, issue_op};
    assign {issue.rs1, issue.rs2, issue.rs3} = {issue_rs1, issue_rs2, issue_rs3};
    assign issue_ready = issue.ready;

    assign {wb.valid, wb.wis, wb.rd, wb.tmask, wb.data, wb.sop, wb.eop}
        = {wb_valid, wb_wis, wb_rd, wb_tmask, wb_data, wb_sop, wb_eop};

    assign opd.ready = opd_ready;
    assign {opd_valid, opd_uuid, opd_wis, opd_tmask, opd_pc, opd_rd, opd_op}
        = {opd.valid, opd.uuid, opd.wis, opd.tmask, opd.pc, opd.rd, opd.op};
    assign {opd_rs1_data, opd_rs2_data, opd_rs3_data} = {opd.rs1_data, opd.rs2_data, opd.rs3_data};

    operand_collector #(
        .THREAD_CNT   (THREAD_CNT),
        .CACHE_ENABLE (CACHE_ENABLE)
    ) i_operand_collector (
        .clk   (clk),
        .reset (reset),
        .issue (issue.slave),
        .wb    (wb.slave),
        .opd   (opd.master)
    );

endmodule

// File: dv/operand_unit_asserts.sv
module operand_unit_asserts #(
    parameter int THREAD_CNT = gpu_config_pkg::NUM_LANES
) (
    input logic                                             clk,
    input logic                                             reset,
    input logic                                             issue_valid,
    input logic                                             issue_ready,
    input logic [gpu_config_pkg::UUID_BITS-1:0]             issue_uuid,
    input logic [gpu_config_pkg::WIS_BITS-1:0]              issue_wis,
    input logic [THREAD_CNT-1:0]                            issue_tmask,
    input logic [gpu_config_pkg::XLEN-1:0]                  issue_pc,
    input logic [gpu_config_pkg::NR_BITS-1:0]               issue_rd,
    input logic [gpu_config_pkg::OP_BITS-1:0]               issue_op,
    input logic [gpu_config_pkg::NR_BITS-1:0]               issue_rs1,
    input logic [gpu_config_pkg::NR_BITS-1:0]               issue_rs2,
    input logic [gpu_config_pkg::NR_BITS-1:0]               issue_rs3,
    input logic                                             opd_valid,
    input logic                                             opd_ready,
    input logic [gpu_config_pkg::UUID_BITS-1:0]             opd_uuid,
    input logic [gpu_config_pkg::WIS_BITS-1:0]              opd_wis,
    input logic [THREAD_CNT-1:0]                            opd_tmask,
    input logic [gpu_config_pkg::XLEN-1:0]                  opd_pc,
    input logic [gpu_config_pkg::NR_BITS-1:0]               opd_rd,
    input logic [gpu_config_pkg::OP_BITS-1:0]               opd_op,
    input logic [THREAD_CNT-1:0][gpu_config_pkg::XLEN-1:0]  opd_rs1_data,
    input logic [THREAD_CNT-1:0][gpu_config_pkg::XLEN-1:0]  opd_rs2_data,
    input logic [THREAD_CNT-1:0][gpu_config_pkg::XLEN-1:0]  opd_rs3_data
);
    // The output buffer comes out of reset empty
    assert property (@(posedge clk) reset |=> !opd_valid)
        else $error("opd_valid high during or right after reset");

    assert property (@(posedge clk) disable iff (reset)
        opd_valid && !opd_ready |=> opd_valid
            && $stable({opd_uuid, opd_wis, opd_tmask, opd_pc, opd_rd, opd_op,
                        opd_rs1_data, opd_rs2_data, opd_rs3_data}))
        else $error("Stalled operand output dropped or changed");

    assert property (@(posedge clk) disable iff (reset)
        issue_valid && !issue_ready |=> issue_valid
            && $stable({issue_uuid, issue_wis, issue_tmask, issue_pc, issue_rd, issue_op,
                        issue_rs1, issue_rs2, issue_rs3}))
        else $error("Waiting issue request dropped or changed");

endmodule

// File: dv/operand_unit_tb.sv
module operand_unit_tb;
    import gpu_config_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int NUM_RANDOM   = 200;
    localparam int NUM_MIXED    = 24;
    localparam int NUM_DIRECTED = 25;
    localparam int NUM_PLANNED  = NUM_RANDOM + NUM_MIXED + NUM_DIRECTED;

    typedef struct packed {
        logic [UUID_BITS-1:0] uuid;
        logic [WIS_BITS-1:0]  wis;
        logic [NUM_LANES-1:0] tmask;
        logic [XLEN-1:0]      pc;
        logic [NR_BITS-1:0]   rd;
        logic [OP_BITS-1:0]   op;
        logic [NR_BITS-1:0]   rs1;
        logic [NR_BITS-1:0]   rs2;
        logic [NR_BITS-1:0]   rs3;
    } instr_t;

    logic                            clk;
    logic                            reset;
    logic                            issue_valid;
    logic                            issue_ready;
    logic [UUID_BITS-1:0]            issue_uuid;
    logic [WIS_BITS-1:0]             issue_wis;
    logic [NUM_LANES-1:0]            issue_tmask;
    logic [XLEN-1:0]                 issue_pc;
    logic [NR_BITS-1:0]              issue_rd;
    logic [OP_BITS-1:0]              issue_op;
    logic [NR_BITS-1:0]              issue_rs1;
    logic [NR_BITS-1:0]              issue_rs2;
    logic [NR_BITS-1:0]              issue_rs3;
    logic                            wb_valid;
    logic [WIS_BITS-1:0]             wb_wis;
    logic [NR_BITS-1:0]              wb_rd;
    logic [NUM_LANES-1:0]            wb_tmask;
    logic [NUM_LANES-1:0][XLEN-1:0]  wb_data;
    logic                            wb_sop;
    logic                            wb_eop;
    logic                            opd_valid;
    logic                            opd_ready;
    logic [UUID_BITS-1:0]            opd_uuid;
    logic [WIS_BITS-1:0]             opd_wis;
    logic [NUM_LANES-1:0]            opd_tmask;
    logic [XLEN-1:0]                 opd_pc;
    logic [NR_BITS-1:0]              opd_rd;
    logic [OP_BITS-1:0]              opd_op;
    logic [NUM_LANES-1:0][XLEN-1:0]  opd_rs1_data;
    logic [NUM_LANES-1:0][XLEN-1:0]  opd_rs2_data;
    logic [NUM_LANES-1:0][XLEN-1:0]  opd_rs3_data;

    // Every lane value the testbench has written, per warp slot and register
    logic [XLEN-1:0]      shadow [NUM_WARP_SLOTS][NUM_REGS][NUM_LANES];
    instr_t               sent_q [$];
    logic [UUID_BITS-1:0] next_uuid;
    bit                   stall_mode;

    operand_unit i_operand_unit (.*);

    bind operand_unit operand_unit_asserts i_operand_unit_asserts (.*);

    function automatic logic [XLEN-1:0] expected_lane(input logic [WIS_BITS-1:0] wis,
                                                      input logic [NR_BITS-1:0] rid,
                                                      input int lane);
        if (rid == '0) begin
            return '0;
        end
        return shadow[wis][rid][lane];
    endfunction

    task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("Error at time %0t: %s expected 0x%h, actual 0x%h",
                     $time, name, expected, actual);
            $display("Verification failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Called and returns on a falling edge
    task automatic issue_instr(input logic [WIS_BITS-1:0] wis, input logic [NUM_LANES-1:0] tmask,
                               input logic [NR_BITS-1:0] rs1, input logic [NR_BITS-1:0] rs2,
                               input logic [NR_BITS-1:0] rs3);
        instr_t ins;
        ins.uuid  = next_uuid;
        ins.wis   = wis;
        ins.tmask = tmask;
        ins.pc    = $urandom;
        ins.rd    = NR_BITS'($urandom);
        ins.op    = OP_BITS'($urandom);
        ins.rs1   = rs1;
        ins.rs2   = rs2;
        ins.rs3   = rs3;
        next_uuid++;
        {issue_uuid, issue_wis, issue_tmask, issue_pc, issue_rd, issue_op} =
            {ins.uuid, ins.wis, ins.tmask, ins.pc, ins.rd, ins.op};
        {issue_rs1, issue_rs2, issue_rs3} = {rs1, rs2, rs3};
        issue_valid = 1'b1;
        // issue_ready comes from registers only, so it is settled here
        while (!issue_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        sent_q.push_back(ins);
        issue_valid = 1'b0;
    endtask

    // Writes wait until no instruction is in flight because the stage has no scoreboard
    task automatic write_back(input logic [WIS_BITS-1:0] wis, input logic [NR_BITS-1:0] rd,
                              input logic [NUM_LANES-1:0] mask, input logic sop,
                              input logic eop);
        logic [NUM_LANES-1:0][XLEN-1:0] data;
        while (sent_q.size() != 0) begin
            @(negedge clk);
        end
        for (int j = 0; j < NUM_LANES; j++) begin
            data[j] = $urandom;
            if (mask[j]) begin
                shadow[wis][rd][j] = data[j];
            end
        end
        {wb_wis, wb_rd, wb_tmask, wb_data, wb_sop, wb_eop} = {wis, rd, mask, data, sop, eop};
        wb_valid = 1'b1;
        @(negedge clk);
        wb_valid = 1'b0;
    endtask

    initial begin : clock_gen
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Long random stretches of back-pressure while stall_mode is set
    initial begin : drive_opd_ready
        int hold;
        hold      = 0;
        opd_ready = 1'b1;
        forever begin
            @(negedge clk);
            if (!stall_mode) begin
                opd_ready = 1'b1;
            end else if (hold == 0) begin
                opd_ready = !opd_ready;
                hold      = opd_ready ? $urandom_range(1, 4) : $urandom_range(4, 24);
            end else begin
                hold--;
            end
        end
    end

    always @(posedge clk) begin : compare_outputs
        instr_t want;
        if (!reset && opd_valid && opd_ready) begin
            if (sent_q.size() == 0) begin
                $display("An output transfer arrived with no instruction outstanding");
                $display("Verification failed");
                $fatal(1, "Unexpected output");
            end else begin
                want = sent_q.pop_front();
                check_value("opd_uuid", XLEN'(want.uuid), XLEN'(opd_uuid));
                check_value("opd_wis", XLEN'(want.wis), XLEN'(opd_wis));
                check_value("opd_tmask", XLEN'(want.tmask), XLEN'(opd_tmask));
                check_value("opd_pc", want.pc, opd_pc);
                check_value("opd_rd", XLEN'(want.rd), XLEN'(opd_rd));
                check_value("opd_op", XLEN'(want.op), XLEN'(opd_op));
                // Inactive lanes carry no defined value
                for (int j = 0; j < NUM_LANES; j++) begin
                    if (want.tmask[j]) begin
                        check_value($sformatf("opd_rs1_data[%0d]", j),
                                    expected_lane(want.wis, want.rs1, j), opd_rs1_data[j]);
                        check_value($sformatf("opd_rs2_data[%0d]", j),
                                    expected_lane(want.wis, want.rs2, j), opd_rs2_data[j]);
                        check_value($sformatf("opd_rs3_data[%0d]", j),
                                    expected_lane(want.wis, want.rs3, j), opd_rs3_data[j]);
                    end
                end
            end
        end
    end

    initial begin : watchdog
        #(NUM_PLANNED * 200 * CLK_PERIOD);
        $display("Timeout, the run did not finish within %0d cycles", NUM_PLANNED * 200);
        $display("Verification failed");
        $fatal(1, "Watchdog expired");
    end

    initial begin : run_tests
        logic [NR_BITS-1:0]   regs [3];
        logic [NR_BITS-1:0]   r;
        logic [WIS_BITS-1:0]  w;
        logic [NUM_LANES-1:0] mask;
        logic [2:0]           pick;
        void'($urandom(11));
        reset       = 1'b1;
        issue_valid = 1'b0;
        {issue_uuid, issue_wis, issue_tmask, issue_pc, issue_rd, issue_op} = '0;
        {issue_rs1, issue_rs2, issue_rs3} = '0;
        {wb_valid, wb_wis, wb_rd, wb_tmask, wb_data, wb_sop, wb_eop} = '0;
        next_uuid   = '0;
        stall_mode  = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Banks are still unwritten, only r0 is safe to read
        check_value("opd_valid", '0, XLEN'(opd_valid));
        issue_instr('0, '1, '0, '0, '0);

        for (int s = 0; s < NUM_WARP_SLOTS; s++) begin
            for (int k = 0; k < NUM_REGS; k++) begin
                write_back(WIS_BITS'(s), NR_BITS'(k), '1, 1'b1, 1'b1);
            end
        end

        for (int s = 0; s < NUM_WARP_SLOTS; s++) begin
            for (int k = 0; k < 3; k++) begin
                regs[k] = NR_BITS'($urandom_range(1, NUM_REGS - 1));
                write_back(WIS_BITS'(s), regs[k], '1, 1'b1, 1'b1);
            end
            issue_instr(WIS_BITS'(s), '1, regs[0], regs[1], regs[2]);
            issue_instr(WIS_BITS'(s), '1, regs[2], '0, regs[0]);
        end
        r = NR_BITS'($urandom_range(1, NUM_REGS - 1));
        for (int s = 0; s < NUM_WARP_SLOTS; s++) begin
            write_back(WIS_BITS'(s), r, '1, 1'b1, 1'b1);
        end
        // Point every slot's cache at r0 so the reads of r come from the banks
        for (int s = 0; s < NUM_WARP_SLOTS; s++) begin
            write_back(WIS_BITS'(s), '0, '1, 1'b1, 1'b1);
        end
        for (int s = 0; s < NUM_WARP_SLOTS; s++) begin
            issue_instr(WIS_BITS'(s), '1, r, r, r);
        end

        // A full-mask read after a partial write mixes old and new lanes
        for (int k = 0; k < 6; k++) begin
            w    = WIS_BITS'($urandom);
            r    = NR_BITS'($urandom_range(1, NUM_REGS - 1));
            mask = NUM_LANES'($urandom_range(1, (1 << NUM_LANES) - 2));
            write_back(w, r, mask, 1'b1, 1'b1);
            issue_instr(w, '1, r, '0, r);
        end
        write_back('0, '0, '1, 1'b1, 1'b1);
        issue_instr('0, '1, '0, '0, '0);

        for (int k = 0; k < 4; k++) begin
            w    = WIS_BITS'($urandom);
            r    = NR_BITS'($urandom_range(1, NUM_REGS - 1));
            mask = NUM_LANES'($urandom_range(1, (1 << NUM_LANES) - 1));
            write_back(w, r, mask, 1'b1, 1'b1);
            issue_instr(w, mask, r, r, '0);
        end
        mask = {NUM_LANES{1'b1}} >> (NUM_LANES / 2);
        r    = NR_BITS'($urandom_range(1, NUM_REGS - 1));
        write_back(2'd1, r, mask, 1'b1, 1'b0);
        write_back(2'd1, r, ~mask, 1'b0, 1'b1);
        issue_instr(2'd1, '1, r, '0, r);

        stall_mode = 1'b1;
        for (int k = 0; k < NUM_RANDOM; k++) begin
            issue_instr(WIS_BITS'($urandom), NUM_LANES'($urandom_range(1, (1 << NUM_LANES) - 1)),
                        NR_BITS'($urandom), NR_BITS'($urandom), NR_BITS'($urandom));
        end
        while (sent_q.size() != 0) begin
            @(negedge clk);
        end
        stall_mode = 1'b0;

        // Zero to three sources per instruction need a bank fetch
        for (int k = 0; k < NUM_MIXED; k++) begin
            pick = 3'(k);
            for (int s = 0; s < 3; s++) begin
                regs[s] = pick[s] ? NR_BITS'($urandom_range(1, NUM_REGS - 1)) : '0;
            end
            issue_instr(WIS_BITS'($urandom), '1, regs[0], regs[1], regs[2]);
        end

        while (sent_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (5) @(negedge clk);
        $display("Verification passed");
        $finish;
    end

endmodule
